// File: compile.f
octree_geom_pkg.sv
searcher_bus_pkg.sv
node_queue.sv
node_fetch.sv
node_decode.sv
feature_fetch.sv
search_sequencer.sv
octree_searcher.sv
tb_octree_model.sv
tb_octree_searcher.sv

// File: feature_fetch.sv
`timescale 1ns/1ps
module feature_fetch (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          go_i,
  input  octree_geom_pkg::queue_entry_t anc_head_i,
  input  logic                          anc_empty_i,
  output logic                          anc_pop_o,
  output searcher_bus_pkg::wb_req_t     wb_req_o,
  input  searcher_bus_pkg::wb_rsp_t     wb_rsp_i,
  output searcher_bus_pkg::wb_data_t    feat_data_o,
  output octree_geom_pkg::pos_code_t    feat_pos_o,
  output logic                          feat_valid_o,
  input  logic                          feat_ready_i,
  output logic                          done_o
);

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_BUS, S_OUT} state_t;

  state_t                     state;
  logic [3:0]                 slot_cnt;
  logic [3:0]                 word_cnt;
  searcher_bus_pkg::wb_addr_t adr_q;
  searcher_bus_pkg::wb_addr_t feat_adr;
  octree_geom_pkg::pos_code_t anc_pos;
  logic [2:0]                 lvl;
  logic [31:0]                hash;
  logic                       cyc;
  logic                       accept;
  logic                       last_word;
  logic                       last_slot;

  assign cyc          = (state == S_BUS);
  assign accept       = (state == S_OUT) && feat_ready_i;
  assign last_word    = (word_cnt == 4'(octree_geom_pkg::FEATURE_LEN - 1));
  assign last_slot    = (slot_cnt == anc_head_i.slots.count - 4'd1);
  assign anc_pop_o    = accept && last_word && last_slot;
  assign done_o       = (state == S_ISSUE) && anc_empty_i;
  assign feat_valid_o = (state == S_OUT);

  assign wb_req_o = '{cyc: cyc, stb: cyc, we: 1'b0, adr: adr_q, dat_w: '0};

  // anchor sits one level below its node, slot as the new offset
  always_comb begin
    lvl = anc_head_i.pos.level;
    anc_pos = anc_head_i.pos;
    anc_pos.level = lvl + 3'd1;
    anc_pos.offset[lvl] = anc_head_i.slots.slot[slot_cnt[2:0]];
    hash = '0;
    for (int i = 0; i < octree_geom_pkg::TREE_LEVEL; i++) begin
      if (i <= lvl) begin
        hash = hash ^ ((32'(anc_pos.offset[i]) + 32'd1) * octree_geom_pkg::PRIMES[i]);
      end
    end
    feat_adr = octree_geom_pkg::FEATURE_BASE +
               hash[octree_geom_pkg::HASH_BITS-1:0] * octree_geom_pkg::FEATURE_LEN + word_cnt;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      slot_cnt <= '0;
      word_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (go_i) begin
            state    <= S_ISSUE;
            slot_cnt <= '0;
            word_cnt <= '0;
          end
        end
        S_ISSUE: begin
          state <= anc_empty_i ? S_IDLE : S_BUS;
        end
        S_BUS: begin
          if (wb_rsp_i.ack) begin
            state <= S_OUT;
          end
        end
        default: begin
          // next read only after the word is taken
          if (feat_ready_i) begin
            state    <= S_ISSUE;
            word_cnt <= last_word ? 4'd0 : word_cnt + 4'd1;
            if (last_word) begin
              slot_cnt <= last_slot ? 4'd0 : slot_cnt + 4'd1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == S_ISSUE) && !anc_empty_i) begin
      adr_q      <= feat_adr;
      feat_pos_o <= anc_pos;
    end
    if (cyc && wb_rsp_i.ack) begin
      feat_data_o <= wb_rsp_i.dat_r;
    end
  end

endmodule

// File: node_decode.sv
`timescale 1ns/1ps
module node_decode (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  octree_geom_pkg::node_beat_t               beat_i,
  input  searcher_bus_pkg::mem_word_u               word_i,
  input  logic [octree_geom_pkg::TREE_LEVEL-1:0]    lod_active_i,
  output logic                                      exp_push_o,
  output logic                                      anc_push_o,
  output octree_geom_pkg::queue_entry_t             push_entry_o,
  output octree_geom_pkg::queue_entry_t             anc_entry_o,
  output logic                                      busy_o
);

  octree_geom_pkg::node_entry_t entry;
  logic [7:0]                   child_mask;
  logic [7:0]                   self_mask;
  octree_geom_pkg::slot_list_t  child_list;
  octree_geom_pkg::slot_list_t  self_list;
  logic                         active;

  // set bits to an ascending slot list
  function automatic octree_geom_pkg::slot_list_t compress(input logic [7:0] mask);
    octree_geom_pkg::slot_list_t list;
    list = '0;
    for (int i = 0; i < octree_geom_pkg::CHILDREN_NUM; i++) begin
      if (mask[i]) begin
        list.slot[list.count[2:0]] = 3'(i);
        list.count = list.count + 4'd1;
      end
    end
    return list;
  endfunction

  always_comb begin
    entry = word_i.node[beat_i.entry];
    for (int i = 0; i < octree_geom_pkg::CHILDREN_NUM; i++) begin
      child_mask[i] = entry.pair[i][0];
      self_mask[i]  = entry.pair[i][1];
    end
  end

  assign child_list = compress(child_mask);
  assign self_list  = compress(self_mask);
  assign active     = beat_i.valid && lod_active_i[beat_i.pos.level];
  assign busy_o     = beat_i.valid || exp_push_o || anc_push_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_push_o <= 1'b0;
      anc_push_o <= 1'b0;
    end else begin
      // leaves at the last level are never expanded
      exp_push_o <= active && (child_list.count != '0) &&
                    (beat_i.pos.level < 3'(octree_geom_pkg::TREE_LEVEL - 1));
      anc_push_o <= active && (self_list.count != '0);
    end
  end

  always_ff @(posedge clk) begin
    push_entry_o <= '{pos: beat_i.pos, slots: child_list};
    anc_entry_o  <= '{pos: beat_i.pos, slots: self_list};
  end

endmodule

// File: node_fetch.sv
`timescale 1ns/1ps
module node_fetch (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          go_i,
  input  octree_geom_pkg::queue_entry_t exp_head_i,
  input  logic                          exp_empty_i,
  input  octree_geom_pkg::qcnt_t        exp_free_i,
  input  octree_geom_pkg::qcnt_t        anc_free_i,
  output logic                          exp_pop_o,
  output searcher_bus_pkg::wb_req_t     wb_req_o,
  input  searcher_bus_pkg::wb_rsp_t     wb_rsp_i,
  output octree_geom_pkg::node_beat_t   beat_o,
  output searcher_bus_pkg::mem_word_u   word_o,
  output logic                          idle_o
);

  logic                       cyc_q;
  logic                       root_q;
  searcher_bus_pkg::wb_addr_t adr_q;
  logic [3:0]                 slot_cnt;
  octree_geom_pkg::pos_code_t cur_pos;
  logic [1:0]                 cur_entry;
  octree_geom_pkg::pos_code_t next_pos;
  logic [11:0]                node_idx;
  searcher_bus_pkg::wb_addr_t next_adr;
  logic                       ack;
  logic                       last_slot;
  logic                       room;
  logic                       start;

  assign ack       = cyc_q && wb_rsp_i.ack;
  assign last_slot = (slot_cnt == exp_head_i.slots.count - 4'd1);
  // one decode may still push, so keep two places in each queue
  assign room      = (exp_free_i >= 2) && (anc_free_i >= 2);
  assign start     = !cyc_q && (go_i || (!exp_empty_i && room));
  assign exp_pop_o = ack && !root_q && last_slot;
  assign idle_o    = !cyc_q && !go_i;

  assign wb_req_o = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, adr: adr_q, dat_w: '0};

  // child of the head at the current slot, or the root on go
  always_comb begin
    next_pos = exp_head_i.pos;
    next_pos.level = exp_head_i.pos.level + 3'd1;
    next_pos.offset[exp_head_i.pos.level] = exp_head_i.slots.slot[slot_cnt[2:0]];
    if (go_i) begin
      next_pos = '0;
    end
    node_idx = '0;
    for (int i = 0; i < octree_geom_pkg::TREE_LEVEL; i++) begin
      if (i < next_pos.level) begin
        node_idx = {node_idx[8:0], next_pos.offset[i]};
      end
    end
    next_adr = octree_geom_pkg::LEVEL_BASE[next_pos.level] + node_idx[11:2];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q    <= 1'b0;
      root_q   <= 1'b0;
      slot_cnt <= '0;
      beat_o   <= '0;
    end else begin
      beat_o.valid <= 1'b0;
      if (start) begin
        cyc_q  <= 1'b1;
        root_q <= go_i;
        if (go_i) begin
          slot_cnt <= '0;
        end
      end else if (ack) begin
        cyc_q  <= 1'b0;
        beat_o <= '{pos: cur_pos, entry: cur_entry, valid: 1'b1};
        if (!root_q) begin
          slot_cnt <= last_slot ? 4'd0 : slot_cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      adr_q     <= next_adr;
      cur_pos   <= next_pos;
      cur_entry <= node_idx[1:0];
    end
    if (ack) begin
      word_o.raw <= wb_rsp_i.dat_r;
    end
  end

endmodule

// File: node_queue.sv
`timescale 1ns/1ps
module node_queue #(
  parameter int DEPTH = 16
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          push_i,
  input  octree_geom_pkg::queue_entry_t push_entry_i,
  input  logic                          pop_i,
  output octree_geom_pkg::queue_entry_t head_o,
  output logic                          empty_o,
  output octree_geom_pkg::qcnt_t        free_o
);

  octree_geom_pkg::queue_entry_t mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]      wr_ptr;
  logic [$clog2(DEPTH)-1:0]      rd_ptr;
  octree_geom_pkg::qcnt_t        fill;
  logic                          do_push;
  logic                          do_pop;

  assign do_push = push_i && (fill != octree_geom_pkg::qcnt_t'(DEPTH));
  assign do_pop  = pop_i && (fill != '0);

  // show-ahead head
  assign head_o  = mem[rd_ptr];
  assign empty_o = (fill == '0);
  assign free_o  = octree_geom_pkg::qcnt_t'(DEPTH) - fill;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_entry_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill <= fill + octree_geom_pkg::qcnt_t'(do_push) - octree_geom_pkg::qcnt_t'(do_pop);
    end
  end

endmodule

// File: octree_geom_pkg.sv
package octree_geom_pkg;

  localparam int TREE_LEVEL       = 5;
  localparam int CHILDREN_NUM     = 8;
  localparam int LEVEL_BITS       = 3;
  localparam int ENTRIES_PER_WORD = 4;

  // first word of each level, four node entries per word
  localparam logic [TREE_LEVEL-1:0][15:0] LEVEL_BASE = {16'd147, 16'd19, 16'd3, 16'd1, 16'd0};

  localparam int FEATURE_BASE = 1200;
  localparam int FEATURE_LEN  = 9;
  localparam int HASH_BITS    = 11;

  // PRIMES[0] applies to the level 0 offset
  localparam logic [TREE_LEVEL-1:0][31:0] PRIMES = {
    32'd2099719, 32'd3867465, 32'd807545, 32'd2654435, 32'd1
  };

  localparam int EXP_DEPTH = 16;
  localparam int ANC_DEPTH = 64;
  localparam int QCNT_W    = $clog2(ANC_DEPTH + 1);

  typedef logic [QCNT_W-1:0] qcnt_t;

  // offsets above the level stay zero
  typedef struct packed {
    logic [LEVEL_BITS-1:0]                 level;
    logic [TREE_LEVEL-1:0][LEVEL_BITS-1:0] offset;
  } pos_code_t;

  typedef struct packed {
    logic [CHILDREN_NUM-1:0][LEVEL_BITS-1:0] slot;
    logic [3:0]                              count;
  } slot_list_t;

  typedef struct packed {
    pos_code_t  pos;
    slot_list_t slots;
  } queue_entry_t;

  // pair[i][0] is the child bit, pair[i][1] the self bit
  typedef struct packed {
    logic [CHILDREN_NUM-1:0][1:0] pair;
  } node_entry_t;

  typedef struct packed {
    pos_code_t  pos;
    logic [1:0] entry;
    logic       valid;
  } node_beat_t;

endpackage

// File: octree_searcher.sv
`timescale 1ns/1ps
module octree_searcher (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   search_start_i,
  output logic                                   search_done_o,
  input  logic [octree_geom_pkg::TREE_LEVEL-1:0] lod_active_i,
  output searcher_bus_pkg::wb_req_t              wb_req_o,
  input  searcher_bus_pkg::wb_rsp_t              wb_rsp_i,
  output searcher_bus_pkg::wb_data_t             feat_data_o,
  output octree_geom_pkg::pos_code_t             feat_pos_o,
  output logic                                   feat_valid_o,
  input  logic                                   feat_ready_i
);

  logic                          fetch_go;
  logic                          feat_go;
  logic                          fetch_idle;
  logic                          decode_busy;
  logic                          feat_done;
  searcher_bus_pkg::wb_req_t     fetch_req;
  searcher_bus_pkg::wb_req_t     feat_req;
  searcher_bus_pkg::wb_rsp_t     fetch_rsp;
  searcher_bus_pkg::wb_rsp_t     feat_rsp;
  octree_geom_pkg::node_beat_t   beat;
  searcher_bus_pkg::mem_word_u   word;
  logic                          exp_push;
  logic                          exp_pop;
  logic                          exp_empty;
  octree_geom_pkg::qcnt_t        exp_free;
  octree_geom_pkg::queue_entry_t exp_entry;
  octree_geom_pkg::queue_entry_t exp_head;
  logic                          anc_push;
  logic                          anc_pop;
  logic                          anc_empty;
  octree_geom_pkg::qcnt_t        anc_free;
  octree_geom_pkg::queue_entry_t anc_entry;
  octree_geom_pkg::queue_entry_t anc_head;

  search_sequencer u_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .search_start_i (search_start_i),
    .search_done_o  (search_done_o),
    .fetch_go_o     (fetch_go),
    .feat_go_o      (feat_go),
    .exp_empty_i    (exp_empty),
    .fetch_idle_i   (fetch_idle),
    .decode_busy_i  (decode_busy),
    .feat_done_i    (feat_done),
    .fetch_req_i    (fetch_req),
    .feat_req_i     (feat_req),
    .fetch_rsp_o    (fetch_rsp),
    .feat_rsp_o     (feat_rsp),
    .wb_rsp_i       (wb_rsp_i),
    .wb_req_o       (wb_req_o)
  );

  node_fetch u_node_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .go_i        (fetch_go),
    .exp_head_i  (exp_head),
    .exp_empty_i (exp_empty),
    .exp_free_i  (exp_free),
    .anc_free_i  (anc_free),
    .exp_pop_o   (exp_pop),
    .wb_req_o    (fetch_req),
    .wb_rsp_i    (fetch_rsp),
    .beat_o      (beat),
    .word_o      (word),
    .idle_o      (fetch_idle)
  );

  node_decode u_node_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .beat_i       (beat),
    .word_i       (word),
    .lod_active_i (lod_active_i),
    .exp_push_o   (exp_push),
    .anc_push_o   (anc_push),
    .push_entry_o (exp_entry),
    .anc_entry_o  (anc_entry),
    .busy_o       (decode_busy)
  );

  node_queue #(
    .DEPTH (octree_geom_pkg::EXP_DEPTH)
  ) u_exp_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (exp_push),
    .push_entry_i (exp_entry),
    .pop_i        (exp_pop),
    .head_o       (exp_head),
    .empty_o      (exp_empty),
    .free_o       (exp_free)
  );

  node_queue #(
    .DEPTH (octree_geom_pkg::ANC_DEPTH)
  ) u_anc_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (anc_push),
    .push_entry_i (anc_entry),
    .pop_i        (anc_pop),
    .head_o       (anc_head),
    .empty_o      (anc_empty),
    .free_o       (anc_free)
  );

  feature_fetch u_feature_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .go_i         (feat_go),
    .anc_head_i   (anc_head),
    .anc_empty_i  (anc_empty),
    .anc_pop_o    (anc_pop),
    .wb_req_o     (feat_req),
    .wb_rsp_i     (feat_rsp),
    .feat_data_o  (feat_data_o),
    .feat_pos_o   (feat_pos_o),
    .feat_valid_o (feat_valid_o),
    .feat_ready_i (feat_ready_i),
    .done_o       (feat_done)
  );

endmodule

// File: search_sequencer.sv
`timescale 1ns/1ps
module search_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      search_start_i,
  output logic                      search_done_o,
  output logic                      fetch_go_o,
  output logic                      feat_go_o,
  input  logic                      exp_empty_i,
  input  logic                      fetch_idle_i,
  input  logic                      decode_busy_i,
  input  logic                      feat_done_i,
  input  searcher_bus_pkg::wb_req_t fetch_req_i,
  input  searcher_bus_pkg::wb_req_t feat_req_i,
  output searcher_bus_pkg::wb_rsp_t fetch_rsp_o,
  output searcher_bus_pkg::wb_rsp_t feat_rsp_o,
  input  searcher_bus_pkg::wb_rsp_t wb_rsp_i,
  output searcher_bus_pkg::wb_req_t wb_req_o
);

  typedef enum logic [1:0] {IDLE, SEARCH, OUTPUT, DONE} state_t;

  state_t state;
  logic   search_end;

  // nothing queued, nothing on the bus, nothing left to decode
  assign search_end    = exp_empty_i && fetch_idle_i && !decode_busy_i;
  assign search_done_o = (state == OUTPUT) && feat_done_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      fetch_go_o <= 1'b0;
      feat_go_o  <= 1'b0;
    end else begin
      fetch_go_o <= 1'b0;
      feat_go_o  <= 1'b0;
      case (state)
        IDLE: begin
          if (search_start_i) begin
            fetch_go_o <= 1'b1;
            state      <= SEARCH;
          end
        end
        SEARCH: begin
          if (search_end) begin
            feat_go_o <= 1'b1;
            state     <= OUTPUT;
          end
        end
        OUTPUT: begin
          if (feat_done_i) begin
            state <= DONE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // bus owner follows the phase
  always_comb begin
    wb_req_o    = '0;
    fetch_rsp_o = '0;
    feat_rsp_o  = '0;
    if (state == SEARCH) begin
      wb_req_o    = fetch_req_i;
      fetch_rsp_o = wb_rsp_i;
    end else if (state == OUTPUT) begin
      wb_req_o   = feat_req_i;
      feat_rsp_o = wb_rsp_i;
    end
  end

endmodule

// File: searcher_bus_pkg.sv
package searcher_bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;

  typedef logic [ADDR_W-1:0] wb_addr_t;
  typedef logic [DATA_W-1:0] wb_data_t;

  // classic wishbone, reads only
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
  } wb_req_t;

  typedef struct packed {
    wb_data_t dat_r;
    logic     ack;
  } wb_rsp_t;

  // a tree word holds four node entries, a feature word is raw
  typedef union packed {
    octree_geom_pkg::node_entry_t [octree_geom_pkg::ENTRIES_PER_WORD-1:0] node;
    wb_data_t                                                             raw;
  } mem_word_u;

endpackage

// File: tb_octree_model.sv
`timescale 1ns/1ps
module tb_octree_model (
  input  logic                      clk,
  input  logic                      rst_n,
  input  searcher_bus_pkg::wb_req_t wb_req_i,
  output searcher_bus_pkg::wb_rsp_t wb_rsp_o,
  output logic                      ready_o
);

  localparam logic [63:0] FEAT_PATTERN = 64'h5a3c_96e1_0ff0_c3a5;
  localparam int          TREE_WORDS   = octree_geom_pkg::FEATURE_BASE;

  logic [63:0]                tree [TREE_WORDS];
  logic [15:0]                lfsr = 16'd5434;
  logic [1:0]                 ack_wait = 2'd0;
  logic [1:0]                 wait_cnt = 2'd0;
  logic                       ready_q = 1'b1;
  searcher_bus_pkg::wb_rsp_t  rsp_q = '0;
  octree_geom_pkg::pos_code_t exp_pos [1024];
  logic [63:0]                exp_data [1024];
  int                         exp_cnt;

  assign ready_o  = ready_q;
  assign wb_rsp_o = rsp_q;

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [63:0] mem_read(input logic [31:0] adr);
    if (adr < TREE_WORDS) begin
      return tree[adr];
    end
    return {32'd0, adr} ^ FEAT_PATTERN;
  endfunction

  // one bit for ready each cycle and two more per ack delay
  always @(negedge clk) begin
    lfsr = lfsr_next(lfsr);
    ready_q = lfsr[0];
    if (rsp_q.ack) begin
      lfsr = lfsr_next(lfsr);
      ack_wait[1] = lfsr[0];
      lfsr = lfsr_next(lfsr);
      ack_wait[0] = lfsr[0];
    end
  end

  // responses change on the falling edge
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_q    <= '0;
      wait_cnt <= '0;
    end else begin
      rsp_q.ack <= 1'b0;
      if (wb_req_i.cyc && wb_req_i.stb && !rsp_q.ack) begin
        if (wait_cnt == ack_wait) begin
          rsp_q    <= '{dat_r: mem_read(wb_req_i.adr), ack: 1'b1};
          wait_cnt <= '0;
        end else begin
          wait_cnt <= wait_cnt + 2'd1;
        end
      end
    end
  end

  task automatic clear_tree();
    for (int i = 0; i < TREE_WORDS; i++) begin
      tree[i] = '0;
    end
  endtask

  // child bit at 2s and self bit at 2s+1 of the 16-bit entry
  task automatic set_node(input int level, input int idx, input logic [7:0] child_mask,
                          input logic [7:0] self_mask);
    int word;
    int base;
    word = octree_geom_pkg::LEVEL_BASE[level] + idx / 4;
    base = (idx % 4) * 16;
    for (int s = 0; s < 8; s++) begin
      tree[word][base + 2 * s]     = child_mask[s];
      tree[word][base + 2 * s + 1] = self_mask[s];
    end
  endtask

  // breadth first walk with slots ascending and lod gating
  task automatic build_expected(input logic [4:0] lod_mask);
    octree_geom_pkg::pos_code_t node_q [512];
    octree_geom_pkg::pos_code_t pos;
    octree_geom_pkg::pos_code_t anc;
    int                         head;
    int                         tail;
    int                         lvl;
    int                         idx;
    int                         hash;
    logic [15:0]                entry;
    head      = 0;
    tail      = 1;
    exp_cnt   = 0;
    node_q[0] = '0;
    while (head < tail) begin
      pos = node_q[head];
      head++;
      lvl = pos.level;
      idx = 0;
      for (int i = 0; i < lvl; i++) begin
        idx = idx * 8 + pos.offset[i];
      end
      entry = tree[octree_geom_pkg::LEVEL_BASE[lvl] + idx / 4][(idx % 4) * 16 +: 16];
      if (lod_mask[lvl]) begin
        for (int s = 0; s < 8; s++) begin
          anc = pos;
          anc.level = lvl + 1;
          anc.offset[lvl] = s;
          if (entry[2 * s] && lvl < octree_geom_pkg::TREE_LEVEL - 1) begin
            node_q[tail] = anc;
            tail++;
          end
          if (entry[2 * s + 1]) begin
            hash = 0;
            for (int i = 0; i <= lvl; i++) begin
              hash = hash ^ ((anc.offset[i] + 1) * octree_geom_pkg::PRIMES[i]);
            end
            hash = hash & ((1 << octree_geom_pkg::HASH_BITS) - 1);
            for (int w = 0; w < octree_geom_pkg::FEATURE_LEN; w++) begin
              exp_pos[exp_cnt]  = anc;
              exp_data[exp_cnt] = mem_read(octree_geom_pkg::FEATURE_BASE +
                                           hash * octree_geom_pkg::FEATURE_LEN + w);
              exp_cnt++;
            end
          end
        end
      end
    end
  endtask

endmodule

// File: tb_octree_searcher.sv
`timescale 1ns/1ps
module tb_octree_searcher;

  logic                       clk;
  logic                       rst_n;
  logic                       search_start;
  logic [4:0]                 lod;
  logic                       stall_en;
  logic                       rand_ready;
  logic                       feat_ready;
  searcher_bus_pkg::wb_req_t  wb_req;
  searcher_bus_pkg::wb_rsp_t  wb_rsp;
  searcher_bus_pkg::wb_data_t feat_data;
  octree_geom_pkg::pos_code_t feat_pos;
  logic                       feat_valid;
  logic                       search_done;
  int                         errors;
  int                         timeouts;
  int                         words;
  int                         dones;

  assign feat_ready = stall_en ? rand_ready : 1'b1;

  octree_searcher dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .search_start_i (search_start),
    .search_done_o  (search_done),
    .lod_active_i   (lod),
    .wb_req_o       (wb_req),
    .wb_rsp_i       (wb_rsp),
    .feat_data_o    (feat_data),
    .feat_pos_o     (feat_pos),
    .feat_valid_o   (feat_valid),
    .feat_ready_i   (feat_ready)
  );

  tb_octree_model u_model (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp),
    .ready_o  (rand_ready)
  );

  always #2 clk = ~clk;

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got == exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // outputs are settled at the rising edge
  always @(posedge clk) begin
    if (rst_n && wb_req.cyc) begin
      check_value("we during a bus cycle", wb_req.we, 0);
    end
    if (rst_n && feat_valid && feat_ready) begin
      if (words < u_model.exp_cnt) begin
        check_value($sformatf("word %0d position", words), feat_pos, u_model.exp_pos[words]);
        check_value($sformatf("word %0d data", words), feat_data, u_model.exp_data[words]);
      end else begin
        errors++;
        $display("extra feature word at %0t, more than the %0d expected", $time,
                 u_model.exp_cnt);
      end
      words++;
    end
    if (rst_n && search_done) begin
      dones++;
    end
  end

  task automatic run_search(input logic [4:0] lod_mask);
    int cycles;
    u_model.build_expected(lod_mask);
    @(negedge clk);
    lod          = lod_mask;
    words        = 0;
    dones        = 0;
    search_start = 1'b1;
    @(negedge clk);
    search_start = 1'b0;
    cycles = 0;
    while (dones == 0 && cycles < 20000) begin
      @(negedge clk);
      cycles++;
    end
    if (dones == 0) begin
      timeouts++;
      $display("timeout: search_done_o did not pulse within %0d cycles", cycles);
    end
    // quiet window for stray words or a second done
    repeat (4) @(negedge clk);
    check_value("done pulses", dones, 1);
    check_value("feature words", words, u_model.exp_cnt);
  endtask

  task automatic reset_state_test();
    check_value("cyc after reset", wb_req.cyc, 0);
    check_value("stb after reset", wb_req.stb, 0);
    check_value("feat_valid_o after reset", feat_valid, 0);
    check_value("search_done_o after reset", search_done, 0);
  endtask

  task automatic empty_root_test();
    u_model.clear_tree();
    run_search(5'b11111);
  endtask

  task automatic root_only_test(input logic [7:0] self_mask);
    u_model.clear_tree();
    u_model.set_node(0, 0, 8'h00, self_mask);
    run_search(5'b11111);
  endtask

  // level n index is the offsets read as a base-8 number
  task automatic build_deep_tree();
    u_model.clear_tree();
    u_model.set_node(0, 0, 8'b0000_0101, 8'b1000_0001);
    u_model.set_node(1, 0, 8'b0001_0010, 8'b0100_0000);
    u_model.set_node(1, 2, 8'b1000_0000, 8'b0000_0100);
    u_model.set_node(2, 1, 8'b0000_1000, 8'b0000_0011);
    u_model.set_node(2, 4, 8'b0000_0000, 8'b0001_0000);
    u_model.set_node(2, 23, 8'b0100_0001, 8'b1000_0000);
    u_model.set_node(3, 11, 8'b0000_0000, 8'b0010_0001);
    u_model.set_node(3, 184, 8'b0000_0000, 8'b0000_0110);
    u_model.set_node(3, 190, 8'b0000_0000, 8'b1000_0000);
  endtask

  task automatic lod_gating_test();
    build_deep_tree();
    run_search(5'b11011);
  endtask

  task automatic stall_test();
    build_deep_tree();
    stall_en = 1'b1;
    run_search(5'b11111);
    stall_en = 1'b0;
  endtask

  task automatic back_to_back_test();
    root_only_test(8'b0101_1001);
    build_deep_tree();
    run_search(5'b10111);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    search_start = 1'b0;
    lod          = '1;
    stall_en     = 1'b0;
    errors       = 0;
    timeouts     = 0;
    words        = 0;
    dones        = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    reset_state_test();
    empty_root_test();
    root_only_test(8'b1010_0110);
    lod_gating_test();
    stall_test();
    back_to_back_test();
    $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
